/* Bender.yml */
package:
  name: input_block

sources:
  - include_dirs:
      - source
    files:
      - source/input_pkg.sv
      - source/rec_pkg.sv
      - source/rec_mem_if.sv
      - source/joy_merge.sv
      - source/pause_ctrl.sv
      - source/mouse_paddle.sv
      - source/rec_inputs.sv
      - source/rec_arbiter.sv
      - source/input_top.sv
      - target: test
        files:
          - tests/input_tb.sv

/* project.f */
+incdir+source
source/input_pkg.sv
source/rec_pkg.sv
source/rec_mem_if.sv
source/joy_merge.sv
source/pause_ctrl.sv
source/mouse_paddle.sv
source/rec_inputs.sv
source/rec_arbiter.sv
source/input_top.sv
tests/input_tb.sv

/* source/input_config.svh */
//**********************************************************
// Player input configuration
// Button count, recording RAM size and paddle reset value
//**********************************************************

`ifndef INPUT_CONFIG_SVH
`define INPUT_CONFIG_SVH

// Fire buttons per player
// Moves start, coin and pause in the cabinet word
`define INPUT_BUTTONS 2

// Address width of the recording RAM
// 6 bits give one byte for each of 64 frames
`define INPUT_REC_AW 6

// Paddle position after reset
`define INPUT_PADDLE_INIT 8'h80

`endif

/* source/input_pkg.sv */
//**********************************************************
// Player input types
// Game and cabinet joystick words, the button layout of a
// cabinet joystick and the pause states
//**********************************************************
`include "input_config.svh"

package input_pkg;

    // Right, left, down, up, then fire buttons
    typedef logic [9:0] joy_word_t;

    // Cabinet word with start, coin and pause after the buttons
    typedef logic [15:0] board_joy_t;

    // Bit positions inside a cabinet joystick word
    localparam int JOY_START_BIT = 4 + `INPUT_BUTTONS;
    localparam int JOY_COIN_BIT  = JOY_START_BIT + 1;
    localparam int JOY_PAUSE_BIT = JOY_COIN_BIT + 1;

    // Pause FSM
    typedef enum logic [1:0] {
        RUNNING,
        PAUSED,
        ADVANCE
    } pause_state_e;

endpackage

/* source/input_top.sv */
//**********************************************************
// Player input top level
// Joystick merge, pause, mouse paddle and input recording
// with host readout of the recording
//**********************************************************
`timescale 1ns/1ps
`include "input_config.svh"

module input_top import input_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  board_joy_t               board_joy1,
    input  board_joy_t               board_joy2,
    input  joy_word_t                key_joy1,
    input  joy_word_t                key_joy2,
    input  logic [1:0]               board_coin,
    input  logic [1:0]               board_start,
    input  logic [1:0]               key_coin,
    input  logic [1:0]               key_start,
    input  logic                     key_pause,
    input  logic                     osd_pause,
    input  logic                     key_service,
    input  logic                     vs,
    input  logic                     lvbl,
    input  logic signed [8:0]        mouse_dx,
    input  logic                     mouse_st,
    input  logic [7:0]               hw_paddle,
    input  logic                     ioctl_rd,
    input  logic [`INPUT_REC_AW-1:0] ioctl_addr,
    output joy_word_t                game_joy1,
    output joy_word_t                game_joy2,
    output logic [1:0]               game_coin,
    output logic [1:0]               game_start,
    output logic                     game_pause,
    output logic [7:0]               game_paddle,
    output logic [7:0]               ioctl_merged,
    output logic                     rec_full
);

    logic      joy_pause;
    rec_mem_if rec_mem ();

    joy_merge joy_merge_i (
        .clk         (clk),
        .reset       (reset),
        .board_joy1  (board_joy1),
        .board_joy2  (board_joy2),
        .key_joy1    (key_joy1),
        .key_joy2    (key_joy2),
        .board_coin  (board_coin),
        .board_start (board_start),
        .key_coin    (key_coin),
        .key_start   (key_start),
        .game_joy1   (game_joy1),
        .game_joy2   (game_joy2),
        .game_coin   (game_coin),
        .game_start  (game_start),
        .joy_pause   (joy_pause)
    );

    // Service key steps one frame while paused
    pause_ctrl pause_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .key_pause  (key_pause),
        .joy_pause  (joy_pause),
        .osd_pause  (osd_pause),
        .adv_frame  (key_service),
        .lvbl       (lvbl),
        .game_pause (game_pause)
    );

    mouse_paddle mouse_paddle_i (
        .clk       (clk),
        .reset     (reset),
        .hw_paddle (hw_paddle),
        .mouse_dx  (mouse_dx),
        .mouse_st  (mouse_st),
        .paddle    (game_paddle)
    );

    rec_inputs rec_inputs_i (
        .clk   (clk),
        .reset (reset),
        .vs    (vs),
        .coin  (game_coin[0]),
        .start (game_start[0]),
        .joy   (game_joy1[5:0]),
        .mem   (rec_mem.recorder),
        .full  (rec_full)
    );

    rec_arbiter rec_arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .mem       (rec_mem.memory),
        .host_rd   (ioctl_rd),
        .host_addr (ioctl_addr),
        .host_data (ioctl_merged)
    );

endmodule

/* source/joy_merge.sv */
//**********************************************************
// Joystick merge
// Combines cabinet and keyboard controls into registered
// game joysticks, coins and starts
//**********************************************************
`timescale 1ns/1ps

module joy_merge import input_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  board_joy_t board_joy1,
    input  board_joy_t board_joy2,
    input  joy_word_t  key_joy1,
    input  joy_word_t  key_joy2,
    input  logic [1:0] board_coin,
    input  logic [1:0] board_start,
    input  logic [1:0] key_coin,
    input  logic [1:0] key_start,
    output joy_word_t  game_joy1,
    output joy_word_t  game_joy2,
    output logic [1:0] game_coin,
    output logic [1:0] game_start,
    output logic       joy_pause
);

    logic [1:0] joy_coin;
    logic [1:0] joy_start;

    // Coin and start buttons on the cabinet joysticks
    assign joy_coin  = {board_joy2[JOY_COIN_BIT], board_joy1[JOY_COIN_BIT]};
    assign joy_start = {board_joy2[JOY_START_BIT], board_joy1[JOY_START_BIT]};

    always_ff @(posedge clk) begin
        if (reset) begin
            game_joy1  <= '0;
            game_joy2  <= '0;
            game_coin  <= '0;
            game_start <= '0;
            joy_pause  <= 1'b0;
        end else begin
            game_joy1  <= board_joy1[9:0] | key_joy1;
            game_joy2  <= board_joy2[9:0] | key_joy2;
            game_coin  <= board_coin | key_coin | joy_coin;
            game_start <= board_start | key_start | joy_start;
            // Either player can pause
            joy_pause  <= board_joy1[JOY_PAUSE_BIT] | board_joy2[JOY_PAUSE_BIT];
        end
    end

endmodule

/* source/mouse_paddle.sv */
//**********************************************************
// Mouse paddle
// Moves the paddle by mouse steps with saturation. A moving
// hardware paddle takes over
//**********************************************************
`timescale 1ns/1ps
`include "input_config.svh"

module mouse_paddle (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        hw_paddle,
    input  logic signed [8:0] mouse_dx,
    input  logic              mouse_st,
    output logic [7:0]        paddle
);

    logic [7:0] hw_paddle_l;
    logic [9:0] sum;
    logic [7:0] sat;

    // Ten bits hold any position plus any step
    assign sum = {2'b00, paddle} + {mouse_dx[8], mouse_dx};

    always_comb begin
        if (sum[9])
            sat = 8'h00;
        else if (sum[8])
            sat = 8'hff;
        else
            sat = sum[7:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            paddle      <= `INPUT_PADDLE_INIT;
            hw_paddle_l <= hw_paddle;
        end else begin
            hw_paddle_l <= hw_paddle;
            // Hardware paddle wins over a mouse step
            if (hw_paddle != hw_paddle_l)
                paddle <= hw_paddle;
            else if (mouse_st)
                paddle <= sat;
        end
    end

endmodule

/* source/pause_ctrl.sv */
//**********************************************************
// Pause control
// Toggles pause from keyboard or joystick and steps one
// frame at a time, ending each step on vertical blank
//**********************************************************
`timescale 1ns/1ps

module pause_ctrl import input_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic key_pause,
    input  logic joy_pause,
    input  logic osd_pause,
    input  logic adv_frame,
    input  logic lvbl,
    output logic game_pause
);

    pause_state_e state;
    pause_state_e state_next;
    logic         key_pause_l;
    logic         joy_pause_l;
    logic         adv_frame_l;
    logic         lvbl_l;
    logic         toggle;
    logic         advance;
    logic         lvbl_fall;

    assign toggle    = (key_pause & ~key_pause_l) | (joy_pause & ~joy_pause_l);
    assign advance   = adv_frame & ~adv_frame_l;
    // Start of vertical blank
    assign lvbl_fall = lvbl_l & ~lvbl;

    always_comb begin
        state_next = state;
        case (state)
            RUNNING: begin
                if (toggle)
                    state_next = PAUSED;
            end
            PAUSED: begin
                if (toggle)
                    state_next = RUNNING;
                else if (advance)
                    state_next = ADVANCE;
            end
            ADVANCE: begin
                // A pause press during a step resumes normal play
                if (toggle)
                    state_next = RUNNING;
                else if (lvbl_fall)
                    state_next = PAUSED;
            end
            default: state_next = RUNNING;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RUNNING;
            game_pause  <= 1'b0;
            key_pause_l <= 1'b0;
            joy_pause_l <= 1'b0;
            adv_frame_l <= 1'b0;
            lvbl_l      <= 1'b0;
        end else begin
            state       <= state_next;
            // OSD menu forces pause in any state
            game_pause  <= osd_pause | (state_next == PAUSED);
            key_pause_l <= key_pause;
            joy_pause_l <= joy_pause;
            adv_frame_l <= adv_frame;
            lvbl_l      <= lvbl;
        end
    end

endmodule

/* source/rec_arbiter.sv */
//**********************************************************
// Recording RAM arbiter
// Holds the record bytes. Host reads take the cycle first
// and recorder writes fill the free cycles
//**********************************************************
`timescale 1ns/1ps
`include "input_config.svh"

module rec_arbiter import rec_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    rec_mem_if.memory                mem,
    input  logic                     host_rd,
    input  logic [`INPUT_REC_AW-1:0] host_addr,
    output logic [7:0]               host_data
);

    logic [7:0] ram [0:(1 << `INPUT_REC_AW) - 1];
    mem_owner_e owner;

    always_comb begin
        if (host_rd)
            owner = HOST;
        else if (mem.req)
            owner = RECORDER;
        else
            owner = NONE;
    end

    // One-cycle grant since the recorder drops req right after it
    assign mem.gnt = (owner == RECORDER);

    always_ff @(posedge clk) begin
        if (owner == RECORDER)
            ram[mem.addr] <= mem.wdata;
    end

    always_ff @(posedge clk) begin
        if (reset)
            host_data <= 8'h00;
        else if (owner == HOST)
            host_data <= ram[host_addr];
    end

endmodule

/* source/rec_inputs.sv */
//**********************************************************
// Input recorder
// Stores player 1 coin, start and joystick once per frame
// until the recording RAM is full
//**********************************************************
`timescale 1ns/1ps
`include "input_config.svh"

module rec_inputs import rec_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        vs,
    input  logic        coin,
    input  logic        start,
    input  logic [5:0]  joy,
    rec_mem_if.recorder mem,
    output logic        full
);

    localparam logic [`INPUT_REC_AW-1:0] LAST_ADDR = '1;

    rec_state_e state;
    logic       vs_l;
    logic       vs_rise;

    assign vs_rise = vs & ~vs_l;
    assign full    = (state == FULL);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            mem.req  <= 1'b0;
            mem.addr <= '0;
            vs_l     <= 1'b0;
        end else begin
            vs_l <= vs;
            case (state)
                IDLE: begin
                    if (vs_rise) begin
                        mem.req <= 1'b1;
                        state   <= WRITE;
                    end
                end
                WRITE: begin
                    // Frames during a pending write are dropped
                    if (mem.gnt) begin
                        mem.req <= 1'b0;
                        if (mem.addr == LAST_ADDR) begin
                            state <= FULL;
                        end else begin
                            mem.addr <= mem.addr + 1'b1;
                            state    <= IDLE;
                        end
                    end
                end
                default: begin
                    // Nothing more is recorded until reset
                end
            endcase
        end
    end

    // Record byte held for the whole request
    always_ff @(posedge clk) begin
        if (state == IDLE && vs_rise)
            mem.wdata <= '{coin: coin, start: start, joy: joy};
    end

endmodule

/* source/rec_mem_if.sv */
//**********************************************************
// Recording memory interface
// Write request and grant between recorder and arbiter
//**********************************************************
`timescale 1ns/1ps
`include "input_config.svh"

interface rec_mem_if import rec_pkg::*; ();

    logic                     req;
    logic [`INPUT_REC_AW-1:0] addr;
    rec_byte_t                wdata;
    // Write takes place on the edge that sees gnt high
    logic                     gnt;

    modport recorder (output req, output addr, output wdata, input gnt);
    modport memory (input req, input addr, input wdata, output gnt);

endinterface

/* source/rec_pkg.sv */
//**********************************************************
// Input recording types
// Record byte layout, recorder FSM states and RAM owner
//**********************************************************

package rec_pkg;

    // One frame of player 1 inputs
    typedef struct packed {
        logic       coin;
        logic       start;
        logic [5:0] joy;
    } rec_byte_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        FULL
    } rec_state_e;

    // Owner of the recording RAM in a given cycle
    typedef enum logic [1:0] {
        NONE,
        HOST,
        RECORDER
    } mem_owner_e;

endpackage

/* tests/input_tb.sv */
//************************************************************
// Player input testbench
// Random stimulus on every input, checked each cycle against
// reference models, then a full readback of the recording
//************************************************************
`timescale 1ns/1ps
`include "input_config.svh"

module input_tb import input_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int FRAME_LEN  = 40;
    localparam int FRAMES     = 80;
    localparam int REC_DEPTH  = 1 << `INPUT_REC_AW;
    localparam int RUN_CYCLES = FRAME_LEN * FRAMES;
    // Run, readback and a margin of about a fifth
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + REC_DEPTH + 736;
    // Cabinet word layout after the fire buttons
    localparam int START_BIT = 4 + `INPUT_BUTTONS;
    localparam int COIN_BIT  = START_BIT + 1;
    localparam int PAUSE_BIT = COIN_BIT + 1;

    logic                     clk;
    logic                     reset;
    board_joy_t               board_joy1;
    board_joy_t               board_joy2;
    joy_word_t                key_joy1;
    joy_word_t                key_joy2;
    logic [1:0]               board_coin;
    logic [1:0]               board_start;
    logic [1:0]               key_coin;
    logic [1:0]               key_start;
    logic                     key_pause;
    logic                     osd_pause;
    logic                     key_service;
    logic                     vs;
    logic                     lvbl;
    logic signed [8:0]        mouse_dx;
    logic                     mouse_st;
    logic [7:0]               hw_paddle;
    logic                     ioctl_rd;
    logic [`INPUT_REC_AW-1:0] ioctl_addr;
    joy_word_t                game_joy1;
    joy_word_t                game_joy2;
    logic [1:0]               game_coin;
    logic [1:0]               game_start;
    logic                     game_pause;
    logic [7:0]               game_paddle;
    logic [7:0]               ioctl_merged;
    logic                     rec_full;

    // Reference model state
    joy_word_t    exp_joy1;
    joy_word_t    exp_joy2;
    logic [1:0]   exp_coin;
    logic [1:0]   exp_start;
    logic         exp_pause;
    logic [7:0]   exp_paddle;
    pause_state_e m_state;
    logic         m_joy_pause;
    logic         m_key_l;
    logic         m_joy_l;
    logic         m_adv_l;
    logic         m_lvbl_l;
    logic         m_vs_l;
    logic [7:0]   m_hw_l;
    logic [7:0]   exp_rec [0:REC_DEPTH-1];
    logic [7:0]   rec_byte;
    logic         rec_pending;
    int           rec_count;

    int     errors;
    int     cycles = 0;
    int     reads_checked;
    int     burst_left;
    integer seed;

    input_top input_top_i (
        .clk          (clk),
        .reset        (reset),
        .board_joy1   (board_joy1),
        .board_joy2   (board_joy2),
        .key_joy1     (key_joy1),
        .key_joy2     (key_joy2),
        .board_coin   (board_coin),
        .board_start  (board_start),
        .key_coin     (key_coin),
        .key_start    (key_start),
        .key_pause    (key_pause),
        .osd_pause    (osd_pause),
        .key_service  (key_service),
        .vs           (vs),
        .lvbl         (lvbl),
        .mouse_dx     (mouse_dx),
        .mouse_st     (mouse_st),
        .hw_paddle    (hw_paddle),
        .ioctl_rd     (ioctl_rd),
        .ioctl_addr   (ioctl_addr),
        .game_joy1    (game_joy1),
        .game_joy2    (game_joy2),
        .game_coin    (game_coin),
        .game_start   (game_start),
        .game_pause   (game_pause),
        .game_paddle  (game_paddle),
        .ioctl_merged (ioctl_merged),
        .rec_full     (rec_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Advance the models by one clock and compare with the DUT
    task automatic model_step();
        logic         toggle;
        logic         advance;
        logic         lvbl_fall;
        logic         vs_rise;
        logic         was_pending;
        pause_state_e nxt;
        int           sum;
        @(posedge clk);
        #1;
        // Recorder and RAM, using game outputs from before this edge
        vs_rise = vs & ~m_vs_l;
        was_pending = rec_pending;
        if (ioctl_rd && ioctl_addr < rec_count) begin
            check_value("ioctl_merged", ioctl_merged, exp_rec[ioctl_addr]);
            reads_checked++;
        end
        if (rec_pending && !ioctl_rd) begin
            exp_rec[rec_count] = rec_byte;
            rec_count++;
            rec_pending = 1'b0;
        end
        if (!was_pending && vs_rise && rec_count < REC_DEPTH) begin
            rec_byte = {exp_coin[0], exp_start[0], exp_joy1[5:0]};
            rec_pending = 1'b1;
        end
        m_vs_l = vs;
        // Pause FSM
        toggle = (key_pause & ~m_key_l) | (m_joy_pause & ~m_joy_l);
        advance = key_service & ~m_adv_l;
        lvbl_fall = m_lvbl_l & ~lvbl;
        nxt = m_state;
        case (m_state)
            RUNNING: begin
                if (toggle)
                    nxt = PAUSED;
            end
            PAUSED: begin
                if (toggle)
                    nxt = RUNNING;
                else if (advance)
                    nxt = ADVANCE;
            end
            default: begin
                if (toggle)
                    nxt = RUNNING;
                else if (lvbl_fall)
                    nxt = PAUSED;
            end
        endcase
        m_state = nxt;
        exp_pause = osd_pause | (nxt == PAUSED);
        m_key_l = key_pause;
        m_joy_l = m_joy_pause;
        m_adv_l = key_service;
        m_lvbl_l = lvbl;
        m_joy_pause = board_joy1[PAUSE_BIT] | board_joy2[PAUSE_BIT];
        // Paddle, hardware change first
        if (hw_paddle != m_hw_l) begin
            exp_paddle = hw_paddle;
        end else if (mouse_st) begin
            sum = int'(exp_paddle) + int'(mouse_dx);
            exp_paddle = (sum < 0) ? 8'h00 : (sum > 255) ? 8'hff : 8'(sum);
        end
        m_hw_l = hw_paddle;
        // Joystick merge
        exp_joy1 = board_joy1[9:0] | key_joy1;
        exp_joy2 = board_joy2[9:0] | key_joy2;
        exp_coin = board_coin | key_coin | {board_joy2[COIN_BIT], board_joy1[COIN_BIT]};
        exp_start = board_start | key_start | {board_joy2[START_BIT], board_joy1[START_BIT]};
        check_value("game_joy1", game_joy1, exp_joy1);
        check_value("game_joy2", game_joy2, exp_joy2);
        check_value("game_coin", game_coin, exp_coin);
        check_value("game_start", game_start, exp_start);
        check_value("game_pause", game_pause, exp_pause);
        check_value("game_paddle", game_paddle, exp_paddle);
        check_value("rec_full", rec_full, rec_count == REC_DEPTH);
    endtask

    task automatic drive_inputs(input int cyc);
        int f_cyc;
        int frame;
        f_cyc = cyc % FRAME_LEN;
        frame = cyc / FRAME_LEN;
        // Blank for the last 8 cycles of a frame, sync inside it
        lvbl = f_cyc < FRAME_LEN - 8;
        vs = (f_cyc >= 34) && (f_cyc < 37);
        board_joy1 = $random(seed);
        board_joy1[PAUSE_BIT] = ($random(seed) & 63) == 0;
        board_joy2 = $random(seed);
        board_joy2[PAUSE_BIT] = ($random(seed) & 63) == 0;
        key_joy1 = $random(seed);
        key_joy2 = $random(seed);
        board_coin = $random(seed);
        board_start = $random(seed);
        key_coin = $random(seed);
        key_start = $random(seed);
        key_pause = ($random(seed) & 31) == 0;
        if (($random(seed) & 127) == 0)
            osd_pause = ~osd_pause;
        key_service = ($random(seed) & 15) == 0;
        mouse_st = ($random(seed) & 3) == 0;
        mouse_dx = $random(seed);
        if (($random(seed) & 63) == 0)
            hw_paddle = $random(seed);
        // Host burst longer than a frame holds off one record
        if (f_cyc == 34 && frame % 20 == 10)
            burst_left = FRAME_LEN + 10;
        if (burst_left > 0) begin
            ioctl_rd = 1'b1;
            burst_left--;
        end else begin
            ioctl_rd = ($random(seed) & 7) == 0;
        end
        ioctl_addr = $random(seed);
    endtask

    initial begin
        int cyc;
        seed = 32'hea32_7a2b;
        errors = 0;
        reads_checked = 0;
        burst_left = 0;
        cyc = 0;
        reset = 1'b1;
        {board_joy1, board_joy2, key_joy1, key_joy2} = '0;
        {board_coin, board_start, key_coin, key_start} = '0;
        {key_pause, osd_pause, key_service, vs, lvbl} = '0;
        {mouse_dx, mouse_st, hw_paddle, ioctl_rd, ioctl_addr} = '0;
        {exp_joy1, exp_joy2, exp_coin, exp_start, exp_pause} = '0;
        {m_joy_pause, m_key_l, m_joy_l, m_adv_l, m_lvbl_l, m_vs_l} = '0;
        exp_paddle = `INPUT_PADDLE_INIT;
        m_hw_l = 8'h00;
        m_state = RUNNING;
        rec_pending = 1'b0;
        rec_count = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        while (cyc < RUN_CYCLES || !rec_full) begin
            drive_inputs(cyc);
            model_step();
            cyc++;
        end
        // Readback of every record, each checked on the next cycle
        reads_checked = 0;
        for (int a = 0; a < REC_DEPTH; a++) begin
            drive_inputs(cyc);
            ioctl_rd = 1'b1;
            ioctl_addr = a;
            model_step();
            cyc++;
        end
        assert (reads_checked == REC_DEPTH) else begin
            $display("Readback checked only %0d of %0d records", reads_checked, REC_DEPTH);
            errors++;
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
